// File: include/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// RAM size in 32-bit words
`define RAM_WORDS 4096

// Lockout counter width of the button debouncer
// Lockout lasts 2**DEBOUNCE_BITS cycles
`define DEBOUNCE_BITS 4

// Cycles from reset release to the first SD request
`define POWER_ON_CYCLES 8

// Idle cycles between two SD word requests
`define SD_PACE_CYCLES 2

// Push buttons on the board
`define BUTTON_COUNT 7

`endif

// File: verilog/socPkg.sv
`default_nettype none
`include "soc_config.svh"

package socPkg;

    localparam int ramIndexBits = $clog2(`RAM_WORDS);

    typedef logic [ramIndexBits-1:0] ramIndex_t;

    // Bus address seen as a RAM word index
    typedef struct packed {
        logic [2:0]               region;
        logic [28-ramIndexBits:0] unused;
        ramIndex_t                wordIndex;
    } memView_t;

    // Same address seen as a peripheral register select
    typedef struct packed {
        logic [2:0]  region;
        logic [24:0] unused;
        logic [3:0]  regSelect;
    } ioView_t;

    typedef union packed {
        memView_t memView;
        ioView_t  ioView;
    } busAddr_u;

    typedef struct packed {
        logic        read;
        logic        write;
        busAddr_u    addr;
        logic [31:0] writeData;
    } busReq_t;

    typedef struct packed {
        logic [31:0] readData;
        logic        ready;
        logic        written;
    } busRsp_t;

    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } sdReq_t;

    // Nonzero codes so the LEDs never go dark while booting
    typedef enum logic [2:0] {
        powerOn    = 3'd1,
        readLength = 3'd2,
        waitLength = 3'd3,
        copyWords  = 3'd4,
        running    = 3'd5
    } bootPhase_e;

endpackage

`default_nettype wire

// File: verilog/bootLoader.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module bootLoader import socPkg::*; (
    input  logic        CPUClock,
    input  logic        rstN,
    input  logic        sdBusy,
    input  logic [31:0] sdData,
    output sdReq_t      sdReq,
    output logic        ramWrite,
    output ramIndex_t   ramAddr,
    output logic [31:0] ramData,
    input  logic        ramWritten,
    output bootPhase_e  phase,
    output logic        bootDone
);

    // Shared by the power-on wait and the pacing between requests
    logic [7:0]  delay;
    logic [31:0] remaining;
    logic        sdWait;
    logic        busySeen;
    logic        writePending;
    logic        sdReady;

    // Word is valid once busy went high and has dropped again
    assign sdReady = sdWait && busySeen && !sdBusy;

    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            phase        <= powerOn;
            bootDone     <= 1'b0;
            sdReq.read   <= 1'b0;
            ramWrite     <= 1'b0;
            delay        <= 8'(`POWER_ON_CYCLES - 1);
            sdWait       <= 1'b0;
            busySeen     <= 1'b0;
            writePending <= 1'b0;
        end else begin
            // Strobes are single-cycle pulses
            sdReq.read <= 1'b0;
            ramWrite   <= 1'b0;

            if (sdWait && sdBusy) begin
                busySeen <= 1'b1;
            end

            case (phase)
                powerOn: begin
                    if (delay == 8'd0) begin
                        phase <= readLength;
                    end else begin
                        delay <= delay - 8'd1;
                    end
                end
                readLength: begin
                    if (!sdBusy) begin
                        sdReq.read <= 1'b1;
                        sdReq.addr <= 32'd0;
                        sdWait     <= 1'b1;
                        phase      <= waitLength;
                    end
                end
                waitLength: begin
                    if (sdReady) begin
                        sdWait    <= 1'b0;
                        busySeen  <= 1'b0;
                        remaining <= sdData;
                        ramAddr   <= '0;
                        delay     <= 8'(`SD_PACE_CYCLES);
                        // Empty image, nothing to copy
                        if (sdData == 32'd0) begin
                            phase    <= running;
                            bootDone <= 1'b1;
                        end else begin
                            phase <= copyWords;
                        end
                    end
                end
                copyWords: begin
                    if (writePending) begin
                        if (ramWritten) begin
                            writePending <= 1'b0;
                            ramAddr      <= ramAddr + 1'b1;
                            if (remaining == 32'd1) begin
                                phase    <= running;
                                bootDone <= 1'b1;
                            end else begin
                                remaining <= remaining - 32'd1;
                                delay     <= 8'(`SD_PACE_CYCLES);
                            end
                        end
                    end else if (sdWait) begin
                        if (sdReady) begin
                            sdWait       <= 1'b0;
                            busySeen     <= 1'b0;
                            ramWrite     <= 1'b1;
                            ramData      <= sdData;
                            writePending <= 1'b1;
                        end
                    end else if (delay != 8'd0) begin
                        delay <= delay - 8'd1;
                    end else if (!sdBusy) begin
                        // Image word k sits at SD word k+1
                        sdReq.read <= 1'b1;
                        sdReq.addr <= sdReq.addr + 32'd1;
                        sdWait     <= 1'b1;
                    end
                end
                default: begin
                    // Running until the next reset
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/busDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module busDecoder import socPkg::*; (
    input  logic        CPUClock,
    input  logic        rstN,
    input  busReq_t     cpuReq,
    input  logic        bootDone,
    input  logic        loaderWrite,
    input  ramIndex_t   loaderAddr,
    input  logic [31:0] loaderData,
    output logic        ramRead,
    output logic        ramWrite,
    output ramIndex_t   ramIndex,
    output logic [31:0] ramWriteData,
    input  logic [31:0] ramReadData,
    input  logic        ramReady,
    input  logic        ramWritten,
    input  logic [31:0] buttonWord,
    output logic        ledWrite,
    output logic [7:0]  ledData,
    output busRsp_t     cpuRsp
);

    localparam logic [2:0] regionRam     = 3'd0;
    localparam logic [2:0] regionLed     = 3'd1;
    localparam logic [2:0] regionButtons = 3'd2;

    logic       cpuRead;
    logic       cpuWrite;
    logic       isRam;
    logic [2:0] rspRegion;
    logic       ioReady;
    logic       ioWritten;
    logic       cpuRamWrite;

    // Processor held in reset until boot finishes
    assign cpuRead  = bootDone && cpuReq.read;
    assign cpuWrite = bootDone && cpuReq.write;
    assign isRam    = cpuReq.addr.memView.region == regionRam;

    // Loader owns the RAM during boot
    assign ramRead      = cpuRead && isRam;
    assign ramWrite     = bootDone ? (cpuWrite && isRam) : loaderWrite;
    assign ramIndex     = bootDone ? cpuReq.addr.memView.wordIndex : loaderAddr;
    assign ramWriteData = bootDone ? cpuReq.writeData : loaderData;

    assign ledWrite = cpuWrite && (cpuReq.addr.ioView.region == regionLed);
    assign ledData  = cpuReq.writeData[7:0];

    // IO and unmapped regions answer one cycle after the strobe
    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            ioReady     <= 1'b0;
            ioWritten   <= 1'b0;
            cpuRamWrite <= 1'b0;
            rspRegion   <= regionRam;
        end else begin
            ioReady     <= cpuRead && !isRam;
            ioWritten   <= cpuWrite && !isRam;
            cpuRamWrite <= cpuWrite && isRam;
            if (cpuRead) begin
                rspRegion <= cpuReq.addr.ioView.region;
            end
        end
    end

    always_comb begin
        cpuRsp.ready   = ramReady || ioReady;
        // Loader writes never reach the processor
        cpuRsp.written = ioWritten || (ramWritten && cpuRamWrite);
        case (rspRegion)
            regionRam:     cpuRsp.readData = ramReadData;
            regionButtons: cpuRsp.readData = buttonWord;
            default:       cpuRsp.readData = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ioRegisters.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module ioRegisters import socPkg::*; (
    input  logic                     CPUClock,
    input  logic                     rstN,
    input  logic                     ledWrite,
    input  logic [7:0]               ledData,
    input  bootPhase_e               phase,
    input  logic                     bootDone,
    input  logic [`BUTTON_COUNT-1:0] buttons,
    output logic [7:0]               led,
    output logic [31:0]              buttonWord
);

    logic [7:0] ledReg;

    // Last value written by the processor
    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            ledReg <= 8'd0;
        end else if (ledWrite) begin
            ledReg <= ledData;
        end
    end

    // Readback copy of the debounced buttons
    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            buttonWord <= 32'd0;
        end else begin
            buttonWord <= {{(32 - `BUTTON_COUNT){1'b0}}, buttons};
        end
    end

    // Boot phase on the LEDs until the program runs
    assign led = bootDone ? ledReg : {5'd0, phase};

endmodule

`default_nettype wire

// File: verilog/mainMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module mainMemory import socPkg::*; (
    input  logic        CPUClock,
    input  logic        read,
    input  logic        write,
    input  ramIndex_t   wordIndex,
    input  logic [31:0] writeData,
    output logic [31:0] readData,
    output logic        ready,
    output logic        written
);

    logic [31:0] mem [`RAM_WORDS];

    always_ff @(posedge CPUClock) begin
        if (write) begin
            mem[wordIndex] <= writeData;
        end
        if (read) begin
            readData <= mem[wordIndex];
        end
    end

    // Completion pulses trail their strobe by one cycle
    always_ff @(posedge CPUClock) begin
        ready   <= read;
        written <= write;
    end

endmodule

`default_nettype wire

// File: verilog/buttonDebouncer.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module buttonDebouncer (
    input  logic                     CPUClock,
    input  logic                     rstN,
    input  logic [`BUTTON_COUNT-1:0] raw,
    output logic [`BUTTON_COUNT-1:0] stable
);

    // One lockout counter per button, zero means armed
    logic [`DEBOUNCE_BITS-1:0] lockout [`BUTTON_COUNT];

    always_ff @(posedge CPUClock) begin
        if (!rstN) begin
            stable <= '0;
            for (int i = 0; i < `BUTTON_COUNT; i++) begin
                lockout[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `BUTTON_COUNT; i++) begin
                if (lockout[i] == '0) begin
                    if (raw[i] != stable[i]) begin
                        stable[i]  <= raw[i];
                        lockout[i] <= `DEBOUNCE_BITS'(1);
                    end
                end else begin
                    // Runs until it wraps back to zero
                    lockout[i] <= lockout[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/socTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module socTop import socPkg::*; (
    input  logic                     CPUClock,
    input  logic                     rstN,
    input  busReq_t                  cpuReq,
    output busRsp_t                  cpuRsp,
    output sdReq_t                   sdReq,
    input  logic [31:0]              sdData,
    input  logic                     sdBusy,
    input  logic [`BUTTON_COUNT-1:0] btn,
    output logic [7:0]               led,
    output logic                     cpuReset,
    output logic                     bootDone
);

    bootPhase_e                phase;
    logic                      loaderWrite;
    ramIndex_t                 loaderAddr;
    logic [31:0]               loaderData;
    logic                      ramRead;
    logic                      ramWrite;
    ramIndex_t                 ramIndex;
    logic [31:0]               ramWriteData;
    logic [31:0]               ramReadData;
    logic                      ramReady;
    logic                      ramWritten;
    logic [31:0]               buttonWord;
    logic                      ledWrite;
    logic [7:0]                ledData;
    logic [`BUTTON_COUNT-1:0]  stableButtons;

    assign cpuReset = !bootDone;

    bootLoader loader (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .sdBusy     (sdBusy),
        .sdData     (sdData),
        .sdReq      (sdReq),
        .ramWrite   (loaderWrite),
        .ramAddr    (loaderAddr),
        .ramData    (loaderData),
        .ramWritten (ramWritten),
        .phase      (phase),
        .bootDone   (bootDone)
    );

    busDecoder decoder (
        .CPUClock     (CPUClock),
        .rstN         (rstN),
        .cpuReq       (cpuReq),
        .bootDone     (bootDone),
        .loaderWrite  (loaderWrite),
        .loaderAddr   (loaderAddr),
        .loaderData   (loaderData),
        .ramRead      (ramRead),
        .ramWrite     (ramWrite),
        .ramIndex     (ramIndex),
        .ramWriteData (ramWriteData),
        .ramReadData  (ramReadData),
        .ramReady     (ramReady),
        .ramWritten   (ramWritten),
        .buttonWord   (buttonWord),
        .ledWrite     (ledWrite),
        .ledData      (ledData),
        .cpuRsp       (cpuRsp)
    );

    ioRegisters ioRegs (
        .CPUClock   (CPUClock),
        .rstN       (rstN),
        .ledWrite   (ledWrite),
        .ledData    (ledData),
        .phase      (phase),
        .bootDone   (bootDone),
        .buttons    (stableButtons),
        .led        (led),
        .buttonWord (buttonWord)
    );

    mainMemory ram (
        .CPUClock  (CPUClock),
        .read      (ramRead),
        .write     (ramWrite),
        .wordIndex (ramIndex),
        .writeData (ramWriteData),
        .readData  (ramReadData),
        .ready     (ramReady),
        .written   (ramWritten)
    );

    buttonDebouncer debouncer (
        .CPUClock (CPUClock),
        .rstN     (rstN),
        .raw      (btn),
        .stable   (stableButtons)
    );

endmodule

`default_nettype wire

// File: bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic CPUClock,
    output logic rstN
);

    // 4 ns period
    initial begin
        CPUClock = 1'b0;
        forever #2 CPUClock = ~CPUClock;
    end

    // Reset held for the first three rising edges
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge CPUClock);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// File: bench/sdReaderModel.sv
`timescale 1ns/1ps
`default_nettype none

module sdReaderModel import socPkg::*; (
    input  logic        CPUClock,
    input  logic        rstN,
    input  sdReq_t      sdReq,
    output logic [31:0] sdData,
    output logic        sdBusy
);

    localparam int imageWords = 7;

    logic [31:0] image [imageWords];
    integer      seed;
    int          busyLeft;
    logic [31:0] wordAddr;

    initial begin
        seed     = 32'h5d80;
        sdData   = 32'd0;
        sdBusy   = 1'b0;
        busyLeft = 0;
        wordAddr = 32'd0;
        // Word 0 holds the program length
        image[0] = 32'd6;
        image[1] = 32'h0000_0013;
        image[2] = 32'h1234_50b7;
        image[3] = 32'h0ff0_0093;
        image[4] = 32'hcafe_f00d;
        image[5] = 32'h8000_0001;
        image[6] = 32'h0000_006f;
    end

    always @(posedge CPUClock) begin
        if (!rstN) begin
            sdBusy <= 1'b0;
        end else if (sdReq.read && !sdBusy) begin
            sdBusy   <= 1'b1;
            wordAddr <= sdReq.addr;
            // Busy stays high for 2 to 9 cycles
            busyLeft <= 1 + ($unsigned($random(seed)) % 8);
        end else if (sdBusy) begin
            if (busyLeft == 0) begin
                sdBusy <= 1'b0;
                sdData <= (wordAddr < imageWords) ? image[wordAddr[2:0]] : 32'd0;
            end else begin
                busyLeft <= busyLeft - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/soc_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module socAssertions import socPkg::*; (
    input logic    CPUClock,
    input logic    rstN,
    input busReq_t cpuReq,
    input busRsp_t cpuRsp,
    input logic    loaderWrite,
    input logic    bootDone,
    input logic    cpuReset
);

    // Count of failed assertions
    int failures = 0;

    // Loader stays off the RAM once the program runs
    loaderQuietAfterBoot: assert property (
        @(posedge CPUClock) disable iff (!rstN) bootDone |-> !loaderWrite
    ) else begin
        failures++;
        $error("Loader wrote RAM after boot finished");
    end

    ramReadReady: assert property (
        @(posedge CPUClock) disable iff (!rstN)
        (bootDone && cpuReq.read && cpuReq.addr.memView.region == 3'd0) |=> cpuRsp.ready
    ) else begin
        failures++;
        $error("RAM read not answered one cycle after the strobe");
    end

    // Loader RAM traffic must not show up on the processor bus
    quietWhileReset: assert property (
        @(posedge CPUClock) disable iff (!rstN)
        cpuReset |=> (!cpuRsp.ready && !cpuRsp.written)
    ) else begin
        failures++;
        $error("Processor bus answered while cpuReset was high");
    end

endmodule

bind socTop socAssertions socChecks (
    .CPUClock    (CPUClock),
    .rstN        (rstN),
    .cpuReq      (cpuReq),
    .cpuRsp      (cpuRsp),
    .loaderWrite (loaderWrite),
    .bootDone    (bootDone),
    .cpuReset    (cpuReset)
);

`default_nettype wire

// File: bench/socTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_config.svh"

module socTb import socPkg::*; ();

    localparam int rspTimeout  = 20;
    localparam int bootTimeout = 2000;
    localparam int rstTimeout  = 20;

    typedef enum logic [1:0] {
        opRead,
        opWrite,
        opButtons,
        opWait
    } op_e;

    // For writes the expected column is the LED value afterwards
    typedef struct packed {
        op_e         op;
        busAddr_u    addr;
        logic [31:0] data;
        logic [31:0] expected;
    } step_t;

    logic                     CPUClock;
    logic                     rstN;
    busReq_t                  cpuReq;
    busRsp_t                  cpuRsp;
    sdReq_t                   sdReq;
    logic [31:0]              sdData;
    logic                     sdBusy;
    logic [`BUTTON_COUNT-1:0] btn;
    logic [7:0]               led;
    logic                     cpuReset;
    logic                     bootDone;

    int    errorCount = 0;
    int    checkCount = 0;
    bit    aborted = 1'b0;
    logic  sdReadLast = 1'b0;
    step_t steps [$];

    clockGen clocks (
        .CPUClock (CPUClock),
        .rstN     (rstN)
    );

    sdReaderModel sdModel (
        .CPUClock (CPUClock),
        .rstN     (rstN),
        .sdReq    (sdReq),
        .sdData   (sdData),
        .sdBusy   (sdBusy)
    );

    socTop UUT (
        .CPUClock (CPUClock),
        .rstN     (rstN),
        .cpuReq   (cpuReq),
        .cpuRsp   (cpuRsp),
        .sdReq    (sdReq),
        .sdData   (sdData),
        .sdBusy   (sdBusy),
        .btn      (btn),
        .led      (led),
        .cpuReset (cpuReset),
        .bootDone (bootDone)
    );

    // SD read strobe is one cycle long and only while the reader is idle
    always @(negedge CPUClock) begin
        if (rstN === 1'b1 && sdReq.read !== 1'b0) begin
            if (sdBusy !== 1'b0 || sdReadLast) begin
                errorCount++;
                $display("SD read strobe held too long or raised while busy at %0t",
                         $time);
            end
        end
        sdReadLast = (rstN === 1'b1) && (sdReq.read === 1'b1);
    end

    function automatic step_t makeStep(input op_e op, input logic [31:0] addr,
                                       input logic [31:0] data, input logic [31:0] expected);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.expected = expected;
        return s;
    endfunction

    task automatic checkRsp(input busRsp_t got, input busRsp_t exp, input bit withData);
        checkCount++;
        if (withData && got.readData !== exp.readData) begin
            errorCount++;
            $display("[ERROR] %0t cpuRsp.readData got %h expected %h",
                     $time, got.readData, exp.readData);
        end
        if (got.ready !== exp.ready || got.written !== exp.written) begin
            errorCount++;
            $display("[ERROR] %0t cpuRsp ready/written got %b/%b expected %b/%b",
                     $time, got.ready, got.written, exp.ready, exp.written);
        end
    endtask

    task automatic checkLed(input logic [7:0] got, input logic [7:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("[ERROR] %0t led got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic checkBoot(input logic gotDone, input logic gotReset, input logic expDone);
        checkCount++;
        if (gotDone !== expDone || gotReset !== !expDone) begin
            errorCount++;
            $display("[ERROR] %0t bootDone/cpuReset got %b/%b expected %b/%b",
                     $time, gotDone, gotReset, expDone, !expDone);
        end
    endtask

    task automatic checkCycles(input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("[ERROR] %0t response latency got %0d expected %0d", $time, got, exp);
        end
    endtask

    // One strobe cycle, then wait for ready or written
    task automatic busAccess(input logic isWrite, input busAddr_u addr, input logic [31:0] data,
                             output busRsp_t rsp, output int cycles);
        @(posedge CPUClock);
        cpuReq.read      <= !isWrite;
        cpuReq.write     <= isWrite;
        cpuReq.addr      <= addr;
        cpuReq.writeData <= data;
        @(posedge CPUClock);
        cpuReq.read  <= 1'b0;
        cpuReq.write <= 1'b0;
        cycles = 0;
        do begin
            @(negedge CPUClock);
            cycles++;
            rsp = cpuRsp;
        end while (!(rsp.ready || rsp.written) && cycles < rspTimeout);
    endtask

    task automatic checkedAccess(input logic isWrite, input busAddr_u addr,
                                 input logic [31:0] data, input logic [31:0] expected);
        busRsp_t rsp;
        busRsp_t exp;
        int      cycles;
        busAccess(isWrite, addr, data, rsp, cycles);
        if (!(rsp.ready || rsp.written)) begin
            errorCount++;
            aborted = 1'b1;
            $display("No bus response within %0d cycles for address %h", rspTimeout, addr);
        end else begin
            exp.readData = expected;
            exp.ready    = !isWrite;
            exp.written  = isWrite;
            checkRsp(rsp, exp, !isWrite);
            checkCycles(cycles, 1);
            if (isWrite) begin
                checkLed(led, expected[7:0]);
            end
        end
    endtask

    task automatic applyStep(input step_t s);
        case (s.op)
            opRead:  checkedAccess(1'b0, s.addr, s.data, s.expected);
            opWrite: checkedAccess(1'b1, s.addr, s.data, s.expected);
            opButtons: begin
                @(posedge CPUClock);
                btn <= s.data[`BUTTON_COUNT-1:0];
            end
            default: repeat (s.data) @(posedge CPUClock);
        endcase
    endtask

    initial begin
        int cycles;
        cpuReq = '0;
        btn    = '0;

        // RAM, then LED, buttons with lockout, then an unmapped region
        steps.push_back(makeStep(opRead,    32'h4000_0000, 32'h0, 32'h0));
        steps.push_back(makeStep(opWrite,   32'h0000_0005, 32'h1234_5678, 32'h0));
        steps.push_back(makeStep(opWrite,   32'h0000_0064, 32'hdead_beef, 32'h0));
        steps.push_back(makeStep(opRead,    32'h0000_0005, 32'h0, 32'h1234_5678));
        steps.push_back(makeStep(opRead,    32'h0000_0064, 32'h0, 32'hdead_beef));
        steps.push_back(makeStep(opWrite,   32'h2000_0000, 32'h0000_01a5, 32'ha5));
        steps.push_back(makeStep(opButtons, 32'h0, 32'h04, 32'h0));
        steps.push_back(makeStep(opWait,    32'h0, 32'd24, 32'h0));
        steps.push_back(makeStep(opRead,    32'h4000_0000, 32'h0, 32'h4));
        steps.push_back(makeStep(opButtons, 32'h0, 32'h00, 32'h0));
        steps.push_back(makeStep(opWait,    32'h0, 32'd24, 32'h0));
        steps.push_back(makeStep(opButtons, 32'h0, 32'h08, 32'h0));
        steps.push_back(makeStep(opWait,    32'h0, 32'd2, 32'h0));
        steps.push_back(makeStep(opButtons, 32'h0, 32'h00, 32'h0));
        steps.push_back(makeStep(opRead,    32'h4000_0000, 32'h0, 32'h8));
        steps.push_back(makeStep(opWait,    32'h0, 32'd24, 32'h0));
        steps.push_back(makeStep(opRead,    32'h4000_0000, 32'h0, 32'h0));
        steps.push_back(makeStep(opWrite,   32'ha000_0005, 32'hffff_ffff, 32'ha5));
        steps.push_back(makeStep(opRead,    32'ha000_0005, 32'h0, 32'h0));
        steps.push_back(makeStep(opRead,    32'h0000_0005, 32'h0, 32'h1234_5678));

        cycles = 0;
        while (rstN !== 1'b1 && cycles < rstTimeout) begin
            @(negedge CPUClock);
            cycles++;
        end
        @(negedge CPUClock);
        checkBoot(bootDone, cpuReset, 1'b0);
        checkLed(led, 8'(powerOn));

        // Phase code must stay visible until boot ends
        cycles = 0;
        while (!bootDone && cycles < bootTimeout) begin
            if (led == 8'd0 || led > 8'(running)) begin
                errorCount++;
                $display("[ERROR] %0t led got %h expected %h to %h",
                         $time, led, 8'(powerOn), 8'(running));
            end
            @(negedge CPUClock);
            cycles++;
        end
        if (!bootDone) begin
            errorCount++;
            aborted = 1'b1;
            $display("Boot did not finish within %0d cycles", bootTimeout);
        end else begin
            checkBoot(bootDone, cpuReset, 1'b1);
            checkLed(led, 8'd0);
        end

        // Image word k+1 must sit in RAM word k
        for (int k = 0; k < sdModel.image[0] && !aborted; k++) begin
            checkedAccess(1'b0, 32'(k), 32'h0, sdModel.image[k + 1]);
        end

        for (int i = 0; i < steps.size() && !aborted; i++) begin
            applyStep(steps[i]);
        end

        errorCount += UUT.socChecks.failures;
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
verilog/socPkg.sv
verilog/bootLoader.sv
verilog/busDecoder.sv
verilog/ioRegisters.sv
verilog/mainMemory.sv
verilog/buttonDebouncer.sv
verilog/socTop.sv
bench/clockGen.sv
bench/sdReaderModel.sv
bench/soc_assertions.sv
bench/socTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module socTb -Mdir obj_dir
	./obj_dir/VsocTb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
